/* fetchFrontend.sv */
module fetchFrontend
(
    input  logic                         clk,
    input  logic                         nrst,

    // APB program-load port
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [fetchPkg::PADDR_W-1:0] paddr,
    input  fetchPkg::wordT               pwdata,
    output fetchPkg::wordT               prdata,
    output logic                         pready,
    output logic                         pslverr,

    // decode side
    input  logic                         stall,
    input  fetchPkg::pcSelT              pcSel,
    input  fetchPkg::wordT               target,
    output fetchPkg::wordT               pc2,
    output fetchPkg::wordT               instr2,
    output logic                         instrValid
);

    import fetchPkg::*;

    logic               loadEn;
    logic               loadWe;
    logic [IMEM_AW-1:0] loadAddr;
    wordT               loadData;
    wordT               loadQ;
    logic               run;
    wordT               pc;
    logic               fetchEn;
    wordT               fetchQ;
    logic [CNT_W-1:0]   deliveredCount;

    progLoadApb uLoader
    (
        .clk            (clk),
        .nrst           (nrst),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .loadEn         (loadEn),
        .loadWe         (loadWe),
        .loadAddr       (loadAddr),
        .loadData       (loadData),
        .loadQ          (loadQ),
        .deliveredCount (deliveredCount),
        .run            (run)
    );

    pcGen uPcGen
    (
        .clk     (clk),
        .nrst    (nrst),
        .run     (run),
        .stall   (stall),
        .pcSel   (pcSel),
        .target  (target),
        .pc      (pc),
        .fetchEn (fetchEn)
    );

    // word address, upper pc bits wrap
    instrMem uImem
    (
        .clk       (clk),
        .fetchEn   (fetchEn),
        .fetchAddr (pc[IMEM_AW-1:0]),
        .fetchQ    (fetchQ),
        .loadEn    (loadEn),
        .loadWe    (loadWe),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .loadQ     (loadQ)
    );

    fetchOut uOut
    (
        .clk            (clk),
        .nrst           (nrst),
        .run            (run),
        .fetchEn        (fetchEn),
        .pcSel          (pcSel),
        .pc             (pc),
        .fetchQ         (fetchQ),
        .pc2            (pc2),
        .instr2         (instr2),
        .instrValid     (instrValid),
        .deliveredCount (deliveredCount)
    );

endmodule

/* fetchOut.sv */
module fetchOut
(
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       run,
    input  logic                       fetchEn,
    input  fetchPkg::pcSelT            pcSel,
    input  fetchPkg::wordT             pc,
    input  fetchPkg::wordT             fetchQ,
    output fetchPkg::wordT             pc2,
    output fetchPkg::wordT             instr2,
    output logic                       instrValid,
    output logic [fetchPkg::CNT_W-1:0] deliveredCount
);

    import fetchPkg::*;

    logic validQ;
    logic runQ;
    logic redirect;
    logic deliver;      // advancing edge with a valid slot

    assign redirect = (pcSel == pcBranch) || (pcSel == pcRestart);
    assign deliver  = fetchEn && !redirect;

    // RAM output register doubles as pipe #2 for the instruction
    assign instr2     = fetchQ;
    assign instrValid = validQ && run;

    // pipe #2, holds on stall
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            pc2    <= '0;
            validQ <= 1'b0;
        end
        else if (!run)
        begin
            validQ <= 1'b0;
        end
        else if (fetchEn)
        begin
            pc2    <= pc;
            validQ <= !redirect;    // squash the slot behind a redirect
        end
    end

    // delivered count, restarts when run rises
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            runQ           <= 1'b0;
            deliveredCount <= '0;
        end
        else
        begin
            runQ <= run;
            if (run && !runQ)
            begin
                deliveredCount <= CNT_W'(deliver);
            end
            else if (deliver)
            begin
                deliveredCount <= deliveredCount + 1'b1;
            end
        end
    end

endmodule

/* fetchPkg.sv */
package fetchPkg;

    // datapath width, PC and instruction words share it
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] wordT;

    // instruction memory geometry
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW    = 8;    // low PC bits used, upper bits wrap

    // width of the delivered-instruction counter
    localparam int CNT_W = 16;

    // APB address map, byte addresses
    localparam int PADDR_W = 12;

    localparam logic [PADDR_W-1:0] ADDR_CTRL   = 12'h400;   // bit 0 is run
    localparam logic [PADDR_W-1:0] ADDR_STATUS = 12'h404;   // read only

    // next-PC select from decode
    typedef enum logic [1:0]
    {
        pcSeqNext = 2'd0,   // pc + 1
        pcRestart = 2'd1,   // back to word 0
        pcBranch  = 2'd2,   // take target
        pcHold    = 2'd3    // keep current pc
    } pcSelT;

endpackage

/* filelist.f */
fetchPkg.sv
progLoadApb.sv
instrMem.sv
pcGen.sv
fetchOut.sv
fetchFrontend.sv
tbFetchFrontend.sv

/* instrMem.sv */
module instrMem
(
    input  logic                         clk,

    // fetch port, read only
    input  logic                         fetchEn,
    input  logic [fetchPkg::IMEM_AW-1:0] fetchAddr,
    output fetchPkg::wordT               fetchQ,

    // load port from APB
    input  logic                         loadEn,
    input  logic                         loadWe,
    input  logic [fetchPkg::IMEM_AW-1:0] loadAddr,
    input  fetchPkg::wordT               loadData,
    output fetchPkg::wordT               loadQ
);

    import fetchPkg::*;

    wordT mem [IMEM_DEPTH];

    // fetch read, output holds while not enabled
    always_ff @(posedge clk)
    begin
        if (fetchEn)
        begin
            fetchQ <= mem[fetchAddr];   // old data on a same-cycle write
        end
    end

    // load port, read-first
    always_ff @(posedge clk)
    begin
        if (loadEn)
        begin
            if (loadWe)
            begin
                mem[loadAddr] <= loadData;
            end
            loadQ <= mem[loadAddr];
        end
    end

endmodule

/* pcGen.sv */
module pcGen
(
    input  logic            clk,
    input  logic            nrst,
    input  logic            run,
    input  logic            stall,
    input  fetchPkg::pcSelT pcSel,
    input  fetchPkg::wordT  target,
    output fetchPkg::wordT  pc,
    output logic            fetchEn
);

    import fetchPkg::*;

    wordT pcNext;

    // the front end advances only when running and not stalled
    assign fetchEn = run && !stall;

    // next pc select
    always_comb
    begin
        pcNext = pc + 1'b1;
        case (pcSel)
            pcSeqNext:
            begin
                pcNext = pc + 1'b1;
            end
            pcRestart:
            begin
                pcNext = '0;
            end
            pcBranch:
            begin
                pcNext = target;
            end
            pcHold:
            begin
                pcNext = pc;
            end
        endcase
    end

    // pipe #1
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            pc <= '0;
        end
        else if (!run)
        begin
            pc <= '0;           // parked at word 0 while stopped
        end
        else if (fetchEn)
        begin
            pc <= pcNext;
        end
    end

endmodule

/* progLoadApb.sv */
module progLoadApb
(
    input  logic                         clk,
    input  logic                         nrst,

    // APB slave side
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [fetchPkg::PADDR_W-1:0] paddr,
    input  fetchPkg::wordT               pwdata,
    output fetchPkg::wordT               prdata,
    output logic                         pready,
    output logic                         pslverr,

    // load port of the instruction memory
    output logic                         loadEn,
    output logic                         loadWe,
    output logic [fetchPkg::IMEM_AW-1:0] loadAddr,
    output fetchPkg::wordT               loadData,
    input  fetchPkg::wordT               loadQ,

    // run control and status
    input  logic [fetchPkg::CNT_W-1:0]   deliveredCount,
    output logic                         run
);

    import fetchPkg::*;

    logic accessPh;     // second APB phase
    logic isMem;
    logic isCtrl;
    logic isStatus;
    logic badAddr;
    logic memRead;
    logic rdWait;       // set in the wait cycle of a memory read

    // address decode
    assign isMem    = (paddr[PADDR_W-1:IMEM_AW+2] == '0);   // 0x000..0x3FC
    assign isCtrl   = (paddr == ADDR_CTRL);
    assign isStatus = (paddr == ADDR_STATUS);
    assign badAddr  = !(isMem || isCtrl || isStatus);

    assign accessPh = psel && penable;
    assign memRead  = isMem && !pwrite;

    // memory load port, one strobe per transfer
    assign loadEn   = accessPh && isMem && !rdWait;
    assign loadWe   = accessPh && isMem && pwrite;
    assign loadAddr = paddr[IMEM_AW+1:2];   // word index
    assign loadData = pwdata;

    // memory reads take one wait state, everything else completes at once
    assign pready  = accessPh && (!memRead || rdWait);
    assign pslverr = accessPh && badAddr;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rdWait <= 1'b0;
        end
        else if (rdWait)
        begin
            rdWait <= 1'b0;     // read data returned this cycle
        end
        else if (accessPh && memRead)
        begin
            rdWait <= 1'b1;
        end
    end

    // run register, writes to status are ignored
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            run <= 1'b0;
        end
        else if (accessPh && pwrite && isCtrl)
        begin
            run <= pwdata[0];
        end
    end

    // read data mux
    always_comb
    begin
        prdata = '0;
        if (isMem)
        begin
            prdata = loadQ;     // registered read from the RAM
        end
        else if (isCtrl)
        begin
            prdata[0] = run;
        end
        else if (isStatus)
        begin
            prdata[CNT_W-1:0] = deliveredCount;
            prdata[CNT_W]     = run;
        end
    end

endmodule

/* tbFetchFrontend.sv */
module tbFetchFrontend;

    timeunit 1ns;
    timeprecision 100ps;

    import fetchPkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int N_READS     = 48;
    localparam int SEQ_CYCLES  = 2 * IMEM_DEPTH + 40;  // runs through the wrap twice
    localparam int N_STALLS    = 40;
    localparam int N_REDIRECTS = 60;

    // worst case per phase, stall bursts up to 14 cycles, redirects up to 6
    localparam int TEST_CYCLES = 10 + 2 * IMEM_DEPTH + 3 * N_READS + SEQ_CYCLES
                               + 14 * N_STALLS + 6 * N_REDIRECTS + 80;
    localparam int MAX_CYCLES  = TEST_CYCLES + TEST_CYCLES * 4 / 5;

    logic               clk = 1'b0;
    logic               nrst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [PADDR_W-1:0] paddr;
    wordT               pwdata;
    wordT               prdata;
    logic               pready;
    logic               pslverr;
    logic               stall;
    pcSelT              pcSel;
    wordT               target;
    wordT               pc2;
    wordT               instr2;
    logic               instrValid;

    integer seed;
    int     cycles = 0;

    wordT shadow [IMEM_DEPTH];  // what the testbench loaded

    // model state, as seen just before each rising edge
    wordT             mPc;
    wordT             mPc2;
    wordT             mInstr;
    logic             mValid;
    logic             mRun;
    logic             mRunQ;
    logic [CNT_W-1:0] mCount;

    fetchFrontend DUT
    (
        .clk        (clk),
        .nrst       (nrst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .stall      (stall),
        .pcSel      (pcSel),
        .target     (target),
        .pc2        (pc2),
        .instr2     (instr2),
        .instrValid (instrValid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic wordT expectedInstr(input wordT pcVal);
        return shadow[pcVal[IMEM_AW-1:0]];  // upper pc bits wrap
    endfunction

    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic checkWord(input string label, input wordT expected, input wordT actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t ns: %s expected %h, got %h", $time, label, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkFlag(input string label, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL %0t ns: %s expected %b, got %b", $time, label, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // called at a falling edge, returns at a falling edge with the bus idle
    task automatic apbWrite(input logic [PADDR_W-1:0] addr, input wordT data,
                            input logic expErr);
        int waits;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        @(posedge clk);
        while (!pready)
        begin
            waits++;
            @(posedge clk);
        end
        checkWord("write wait states", '0, wordT'(waits));
        checkFlag("write pslverr", expErr, pslverr);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [PADDR_W-1:0] addr, output wordT data,
                           input int expWaits, input logic expErr);
        int waits;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        @(posedge clk);
        while (!pready)
        begin
            waits++;
            @(posedge clk);
        end
        data = prdata;
        checkWord("read wait states", wordT'(expWaits), wordT'(waits));
        checkFlag("read pslverr", expErr, pslverr);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // reference model built from the fetch timing rules
    always @(posedge clk)
    begin : refModel
        logic adv;
        logic redir;
        adv   = mRun && !stall;
        redir = (pcSel == pcBranch) || (pcSel == pcRestart);
        if (!nrst)
        begin
            mPc    <= '0;
            mPc2   <= '0;
            mInstr <= '0;
            mValid <= 1'b0;
            mRun   <= 1'b0;
            mRunQ  <= 1'b0;
            mCount <= '0;
        end
        else
        begin
            if (!mRun)
            begin
                mPc    <= '0;
                mValid <= 1'b0;
            end
            else if (adv)
            begin
                mPc2   <= mPc;
                mInstr <= expectedInstr(mPc);
                mValid <= !redir;   // slot behind a redirect is squashed
                case (pcSel)
                    pcSeqNext: mPc <= mPc + 1;
                    pcRestart: mPc <= '0;
                    pcBranch:  mPc <= target;
                    pcHold:    mPc <= mPc;
                endcase
            end
            mRunQ <= mRun;
            if (mRun && !mRunQ)
            begin
                mCount <= (adv && !redir) ? CNT_W'(1) : '0;
            end
            else if (adv && !redir)
            begin
                mCount <= mCount + 1'b1;
            end
            // control writes take effect in the first access cycle
            if (psel && penable && pwrite && paddr == ADDR_CTRL)
            begin
                mRun <= pwdata[0];
            end
        end
    end

    // compare decode-side outputs with the model
    always @(posedge clk)
    begin
        if (nrst)
        begin
            checkFlag("instrValid", mValid && mRun, instrValid);
            checkWord("pc2", mPc2, pc2);
            if (mValid && mRun)
            begin
                checkWord("instr2", mInstr, instr2);
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic loadAndReadback();
        wordT        d;
        int unsigned idx;
        for (int i = 0; i < IMEM_DEPTH; i++)
        begin
            d         = wordT'($random(seed));
            shadow[i] = d;
            apbWrite(PADDR_W'(i * 4), d, 1'b0);
        end
        repeat (N_READS)
        begin
            idx = randBelow(IMEM_DEPTH);
            apbRead(PADDR_W'(idx * 4), d, 1, 1'b0);
            checkWord("memory readback", shadow[idx], d);
        end
        // unmapped, aliases word 0 in the low bits
        apbWrite(12'h800, 32'hdead_beef, 1'b1);
        apbRead(12'h800, d, 0, 1'b1);
        apbRead(12'h000, d, 1, 1'b0);
        checkWord("word 0 after bad write", shadow[0], d);
    endtask

    task automatic stallBursts();
        int len;
        repeat (N_STALLS)
        begin
            len   = 1 + randBelow(6);
            stall = 1'b1;
            repeat (len) @(negedge clk);
            stall = 1'b0;
            repeat (1 + randBelow(8)) @(negedge clk);
        end
    endtask

    task automatic redirects();
        int unsigned kind;
        repeat (N_REDIRECTS)
        begin
            kind   = randBelow(3);
            target = wordT'($random(seed));
            if (kind == 0)
            begin
                pcSel = pcBranch;
            end
            else if (kind == 1)
            begin
                pcSel = pcRestart;
            end
            else
            begin
                pcSel = pcHold;
            end
            @(negedge clk);     // one advancing edge with the redirect
            pcSel = pcSeqNext;
            repeat (2 + randBelow(4)) @(negedge clk);
        end
    endtask

    // status read inside a stall window so the count stays frozen
    task automatic statusCheck();
        wordT d;
        stall = 1'b1;
        @(negedge clk);
        apbRead(ADDR_STATUS, d, 0, 1'b0);
        checkWord("status", wordT'({mRun, mCount}), d);
        stall = 1'b0;
    endtask

    task automatic runControl();
        statusCheck();
        repeat (5) @(negedge clk);
        apbWrite(ADDR_CTRL, 32'h0, 1'b0);
        checkFlag("instrValid after stop", 1'b0, instrValid);
        repeat (4) @(negedge clk);
        apbWrite(ADDR_CTRL, 32'h1, 1'b0);
        while (!instrValid)
        begin
            @(negedge clk);
        end
        checkWord("pc2 after restart", '0, pc2);
        repeat (3) @(negedge clk);
        statusCheck();
        repeat (20) @(negedge clk);
    endtask

    initial
    begin
        seed    = 32'h6419_b89b;
        nrst    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        stall   = 1'b0;
        pcSel   = pcSeqNext;
        target  = '0;
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        loadAndReadback();
        apbWrite(ADDR_CTRL, 32'h1, 1'b0);   // start fetching from word 0
        repeat (SEQ_CYCLES) @(negedge clk);
        stallBursts();
        redirects();
        runControl();

        $display("PASS: all tests");
        $finish;
    end

endmodule
